// File: line_pkg.sv
package line_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 64;
    localparam int BEATS       = 8;
    localparam int LINE_BYTES  = 64;
    localparam logic [7:0] BURST_LEN  = 8'd7;
    localparam logic [2:0] BURST_SIZE = 3'd3;      // 8 bytes per beat
    localparam logic [ADDR_W-1:0] BASE_ADDR = 32'h8000_0000;
    localparam int IDLE_CYCLES = 16;
    localparam logic [DATA_W-1:0] PATTERN_SEED = 64'h5a17_c3e9_0b6d_f284;
    // x^64 + x^63 + x^61 + x^60 + 1, right shifting galois form
    localparam logic [DATA_W-1:0] PATTERN_TAPS = 64'hd800_0000_0000_0000;

    typedef union packed {
        logic [BEATS*DATA_W-1:0]      flat;
        logic [BEATS-1:0][DATA_W-1:0] beat;    // beat 0 at the line address
    } line_u;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        line_u             line;
    } xfer_req_t;

    // ordered so that a larger code is the worse response
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
        logic                last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

// File: line_req_gen.sv
`timescale 1ns/100ps

module line_req_gen (
    input  logic                clock,
    input  logic                reset,
    input  logic                run_i,
    input  logic                ack_i,
    output logic                req_valid_o,
    output line_pkg::xfer_req_t req_o
);
    import line_pkg::*;

    typedef logic [$clog2(IDLE_CYCLES)-1:0] idle_cnt_t;

    idle_cnt_t         idle_cnt;
    logic              phase_rd;   // 0 write next, 1 read back
    logic [ADDR_W-1:0] line_addr;
    logic [DATA_W-1:0] lfsr;
    logic              counting;
    logic              fill_beat;
    logic              fire;

    // a new pair needs run_i, the read back of a pair always goes out
    assign counting  = !req_valid_o && (phase_rd || run_i);

    // the first BEATS cycles of a write gap build the line
    assign fill_beat = counting && !phase_rd && (idle_cnt < idle_cnt_t'(BEATS));
    assign fire      = counting && (idle_cnt == idle_cnt_t'(IDLE_CYCLES - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            idle_cnt    <= '0;
            phase_rd    <= 1'b0;
            line_addr   <= BASE_ADDR;
            lfsr        <= PATTERN_SEED;
            req_valid_o <= 1'b0;
        end else begin
            if (ack_i) begin
                req_valid_o <= 1'b0;
                idle_cnt    <= '0;
                phase_rd    <= !phase_rd;
                if (phase_rd) begin
                    line_addr <= line_addr + ADDR_W'(LINE_BYTES);   // pair done
                end
            end else if (fire) begin
                req_valid_o <= 1'b1;
            end else if (counting) begin
                idle_cnt <= idle_cnt + 1'b1;
            end

            // one step per beat, never reseeded
            if (fill_beat) begin
                lfsr <= {1'b0, lfsr[DATA_W-1:1]} ^ (lfsr[0] ? PATTERN_TAPS : '0);
            end
        end
    end

    // request payload, only changes while req_valid_o is low
    always_ff @(posedge clock) begin
        if (fill_beat) begin
            req_o.line.beat[idle_cnt[$clog2(BEATS)-1:0]] <= lfsr;  // current state first
        end
        if (fire) begin
            req_o.write <= !phase_rd;
            req_o.addr  <= line_addr;
            if (phase_rd) begin
                req_o.line <= '0;
            end
        end
    end

endmodule

// File: axi_burst_master.sv
`timescale 1ns/100ps

module axi_burst_master (
    input  logic                clock,
    input  logic                reset,

    input  logic                req_valid_i,
    input  line_pkg::xfer_req_t req_i,
    output logic                ack_o,
    output line_pkg::line_u     rdata_o,
    output line_pkg::axi_resp_e resp_o,

    output logic                aw_valid_o,
    input  logic                aw_ready_i,
    output line_pkg::axi_ax_t   aw_o,

    output logic                w_valid_o,
    input  logic                w_ready_i,
    output line_pkg::axi_w_t    w_o,

    input  logic                b_valid_i,
    output logic                b_ready_o,
    input  line_pkg::axi_b_t    b_i,

    output logic                ar_valid_o,
    input  logic                ar_ready_i,
    output line_pkg::axi_ax_t   ar_o,

    input  logic                r_valid_i,
    output logic                r_ready_o,
    input  line_pkg::axi_r_t    r_i
);
    import line_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,    // read address only
        ST_DATA,    // write AW + W, or read R beats
        ST_RESP,
        ST_DONE
    } state_e;

    typedef logic [$clog2(BEATS)-1:0] beat_idx_t;

    state_e    state;
    beat_idx_t beat_cnt;
    line_u     rline;
    axi_resp_e resp_q;
    axi_ax_t   ax;
    logic      aw_fin;
    logic      w_fin;
    logic      r_hs;

    // req_i is held by the generator until ack, so the payload is stable
    assign ax   = '{addr: req_i.addr, len: BURST_LEN, size: BURST_SIZE, burst: 2'b01};
    assign aw_o = ax;
    assign ar_o = ax;

    assign w_o = '{data: req_i.line.beat[beat_cnt],
                   strb: {(DATA_W/8){1'b1}},
                   last: (beat_cnt == beat_idx_t'(BEATS - 1))};

    // done already, or done in this cycle
    assign aw_fin = !aw_valid_o || aw_ready_i;
    assign w_fin  = !w_valid_o || (w_ready_i && w_o.last);
    assign r_hs   = r_valid_i && r_ready_o;

    assign ack_o   = (state == ST_DONE);
    assign rdata_o = rline;
    assign resp_o  = resp_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ST_IDLE;
            aw_valid_o <= 1'b0;
            w_valid_o  <= 1'b0;
            ar_valid_o <= 1'b0;
            b_ready_o  <= 1'b0;
            r_ready_o  <= 1'b0;
            beat_cnt   <= '0;
            resp_q     <= RESP_OKAY;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        beat_cnt <= '0;
                        resp_q   <= RESP_OKAY;
                        if (req_i.write) begin
                            aw_valid_o <= 1'b1;
                            w_valid_o  <= 1'b1;
                            state      <= ST_DATA;
                        end else begin
                            ar_valid_o <= 1'b1;
                            state      <= ST_ADDR;
                        end
                    end
                end
                ST_ADDR: begin
                    if (ar_ready_i) begin
                        ar_valid_o <= 1'b0;
                        r_ready_o  <= 1'b1;
                        state      <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (req_i.write) begin
                        if (aw_valid_o && aw_ready_i) begin
                            aw_valid_o <= 1'b0;
                        end
                        if (w_valid_o && w_ready_i) begin
                            beat_cnt <= beat_cnt + 1'b1;
                            if (w_o.last) begin
                                w_valid_o <= 1'b0;
                            end
                        end
                        if (aw_fin && w_fin) begin  // either order
                            b_ready_o <= 1'b1;
                            state     <= ST_RESP;
                        end
                    end else if (r_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r_i.resp > resp_q) begin
                            resp_q <= r_i.resp;     // keep the worst
                        end
                        if (r_i.last) begin
                            r_ready_o <= 1'b0;
                            state     <= ST_DONE;
                        end
                    end
                end
                ST_RESP: begin
                    if (b_valid_i && b_ready_o) begin
                        b_ready_o <= 1'b0;
                        resp_q    <= b_i.resp;
                        state     <= ST_DONE;
                    end
                end
                ST_DONE: state <= ST_IDLE;      // ack cycle, req drops after it
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read line assembly
    always_ff @(posedge clock) begin
        if (r_hs) begin
            rline.beat[beat_cnt] <= r_i.data;
        end
    end

endmodule

// File: line_check.sv
`timescale 1ns/100ps

module line_check (
    input  logic                clock,
    input  logic                reset,
    input  logic                req_valid_i,
    input  line_pkg::xfer_req_t req_i,
    input  logic                ack_i,
    input  line_pkg::line_u     rdata_i,
    input  line_pkg::axi_resp_e resp_i,
    output logic [15:0]         pair_count_o,
    output logic [15:0]         mismatch_count_o,
    output logic [15:0]         resp_err_count_o
);
    import line_pkg::*;

    line_u ref_line;    // last line written
    logic  wr_err;      // write half of the pair saw an error
    logic  wr_ack;
    logic  rd_ack;
    logic  rd_err;

    assign wr_ack = ack_i && req_valid_i && req_i.write;
    assign rd_ack = ack_i && req_valid_i && !req_i.write;
    assign rd_err = (resp_i != RESP_OKAY);

    always_ff @(posedge clock) begin
        if (reset) begin
            ref_line         <= '0;
            wr_err           <= 1'b0;
            pair_count_o     <= '0;
            mismatch_count_o <= '0;
            resp_err_count_o <= '0;
        end else begin
            if (wr_ack) begin
                ref_line <= req_i.line;
                wr_err   <= (resp_i != RESP_OKAY);
            end
            if (rd_ack) begin
                pair_count_o <= pair_count_o + 16'd1;
                if (rdata_i.flat != ref_line.flat) begin
                    mismatch_count_o <= mismatch_count_o + 16'd1;
                end
                resp_err_count_o <= resp_err_count_o + 16'(wr_err) + 16'(rd_err);
            end
        end
    end

endmodule

// File: sim_top.sv
`timescale 1ns/100ps

module sim_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              run_i,

    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output line_pkg::axi_ax_t aw_o,

    output logic              w_valid_o,
    input  logic              w_ready_i,
    output line_pkg::axi_w_t  w_o,

    input  logic              b_valid_i,
    output logic              b_ready_o,
    input  line_pkg::axi_b_t  b_i,

    output logic              ar_valid_o,
    input  logic              ar_ready_i,
    output line_pkg::axi_ax_t ar_o,

    input  logic              r_valid_i,
    output logic              r_ready_o,
    input  line_pkg::axi_r_t  r_i,

    output logic [15:0]       pair_count_o,
    output logic [15:0]       mismatch_count_o,
    output logic [15:0]       resp_err_count_o
);
    import line_pkg::*;

    logic      req_valid;
    xfer_req_t req;
    logic      ack;
    line_u     rdata;
    axi_resp_e resp;

    line_req_gen u_req_gen (
        .clock       (clock),
        .reset       (reset),
        .run_i       (run_i),
        .ack_i       (ack),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    axi_burst_master u_master (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (req_valid),
        .req_i       (req),
        .ack_o       (ack),
        .rdata_o     (rdata),
        .resp_o      (resp),
        .aw_valid_o  (aw_valid_o),
        .aw_ready_i  (aw_ready_i),
        .aw_o        (aw_o),
        .w_valid_o   (w_valid_o),
        .w_ready_i   (w_ready_i),
        .w_o         (w_o),
        .b_valid_i   (b_valid_i),
        .b_ready_o   (b_ready_o),
        .b_i         (b_i),
        .ar_valid_o  (ar_valid_o),
        .ar_ready_i  (ar_ready_i),
        .ar_o        (ar_o),
        .r_valid_i   (r_valid_i),
        .r_ready_o   (r_ready_o),
        .r_i         (r_i)
    );

    line_check u_check (
        .clock            (clock),
        .reset            (reset),
        .req_valid_i      (req_valid),
        .req_i            (req),
        .ack_i            (ack),
        .rdata_i          (rdata),
        .resp_i           (resp),
        .pair_count_o     (pair_count_o),
        .mismatch_count_o (mismatch_count_o),
        .resp_err_count_o (resp_err_count_o)
    );

endmodule

// File: axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model (
    input  logic              clock,
    input  logic              reset,
    input  logic [3:0]        stall_rate_i,    // stall when a nibble is below this
    input  logic [19:0]       rnd_i,           // one nibble per channel
    input  logic              inject_slverr_i,
    input  logic              flip_bit_i,

    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  line_pkg::axi_ax_t aw_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    input  line_pkg::axi_w_t  w_i,
    output logic              b_valid_o,
    input  logic              b_ready_i,
    output line_pkg::axi_b_t  b_o,
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    input  line_pkg::axi_ax_t ar_i,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    output line_pkg::axi_r_t  r_o
);
    import line_pkg::*;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];    // sparse, keyed by byte address
    logic [ADDR_W-1:0] wr_addr_q [$];               // every write burst, in order
    line_u             wr_line_q [$];

    logic [4:0]        stall;                       // aw, w, b, ar, r
    logic              have_aw   = 1'b0;
    logic              w_done    = 1'b0;
    logic [2:0]        w_cnt     = '0;
    logic [ADDR_W-1:0] w_addr    = '0;
    line_u             w_buf     = '0;
    logic              b_valid_q = 1'b0;
    axi_b_t            b_q       = '0;
    logic              rd_active = 1'b0;
    logic [2:0]        r_cnt     = '0;
    logic [ADDR_W-1:0] r_addr    = '0;
    logic              r_valid_q = 1'b0;
    axi_r_t            r_q       = '0;

    always_comb begin
        for (int k = 0; k < 5; k++) begin
            stall[k] = (rnd_i[4*k +: 4] < stall_rate_i);
        end
    end

    assign aw_ready_o = !have_aw && !stall[0];
    assign w_ready_o  = !w_done && !stall[1];
    assign ar_ready_o = !rd_active && !r_valid_q && !stall[3];
    assign b_valid_o  = b_valid_q;
    assign b_o        = b_q;
    assign r_valid_o  = r_valid_q;
    assign r_o        = r_q;

    // unwritten words read back a pattern of their own address
    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~a, a};
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            have_aw   <= 1'b0;
            w_done    <= 1'b0;
            w_cnt     <= '0;
            b_valid_q <= 1'b0;
            rd_active <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (aw_valid_i && aw_ready_o) begin
                have_aw <= 1'b1;
                w_addr  <= aw_i.addr;
            end
            if (w_valid_i && w_ready_o) begin
                w_buf.beat[w_cnt] <= w_i.data;
                w_cnt             <= w_cnt + 3'd1;
                w_done            <= w_i.last;
            end

            if (b_valid_q && b_ready_i) begin
                b_valid_q <= 1'b0;
            end else if (have_aw && w_done && !b_valid_q && !stall[2]) begin
                for (int i = 0; i < BEATS; i++) begin
                    mem[w_addr + ADDR_W'(8 * i)] = w_buf.beat[i];
                end
                wr_addr_q.push_back(w_addr);
                wr_line_q.push_back(w_buf);
                b_q.resp  <= inject_slverr_i ? RESP_SLVERR : RESP_OKAY;
                b_valid_q <= 1'b1;
                have_aw   <= 1'b0;
                w_done    <= 1'b0;
                w_cnt     <= '0;
            end

            if (ar_valid_i && ar_ready_o) begin
                rd_active <= 1'b1;
                r_addr    <= ar_i.addr;
                r_cnt     <= '0;
            end
            if (r_valid_q && r_ready_i) begin
                r_valid_q <= 1'b0;
            end
            if (rd_active && (!r_valid_q || r_ready_i) && !stall[4]) begin
                r_q.data  <= read_word(r_addr + ADDR_W'(8 * r_cnt)) ^ DATA_W'(flip_bit_i);
                r_q.resp  <= RESP_OKAY;
                r_q.last  <= (r_cnt == 3'(BEATS - 1));
                r_valid_q <= 1'b1;
                r_cnt     <= r_cnt + 3'd1;
                if (r_cnt == 3'(BEATS - 1)) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

endmodule

// File: line_sva.sv
`timescale 1ns/100ps

module line_sva (
    input logic              clock,
    input logic              reset,
    input logic              aw_valid_i,
    input logic              aw_ready_i,
    input line_pkg::axi_ax_t aw_i,
    input logic              w_valid_i,
    input logic              w_ready_i,
    input line_pkg::axi_w_t  w_i,
    input logic              ar_valid_i,
    input logic              ar_ready_i,
    input line_pkg::axi_ax_t ar_i
);
    import line_pkg::*;

    logic [2:0] w_beat;
    int         fail_count = 0;

    always_ff @(posedge clock) begin
        if (reset) begin
            w_beat <= '0;
        end else if (w_valid_i && w_ready_i) begin
            w_beat <= w_i.last ? 3'd0 : w_beat + 3'd1;
        end
    end

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
        else begin
            fail_count++;
            $error("AW valid dropped or payload changed while stalled");
        end
    w_hold: assert property (@(posedge clock) disable iff (reset)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
        else begin
            fail_count++;
            $error("W valid dropped or payload changed while stalled");
        end
    ar_hold: assert property (@(posedge clock) disable iff (reset)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
        else begin
            fail_count++;
            $error("AR valid dropped or payload changed while stalled");
        end

    // 8 beats of 8 bytes, INCR
    aw_len: assert property (@(posedge clock) disable iff (reset)
        aw_valid_i |-> aw_i.len == BURST_LEN && aw_i.size == BURST_SIZE && aw_i.burst == 2'b01)
        else begin
            fail_count++;
            $error("AW len, size or burst does not describe the line burst");
        end
    ar_len: assert property (@(posedge clock) disable iff (reset)
        ar_valid_i |-> ar_i.len == BURST_LEN && ar_i.size == BURST_SIZE && ar_i.burst == 2'b01)
        else begin
            fail_count++;
            $error("AR len, size or burst does not describe the line burst");
        end

    w_strb: assert property (@(posedge clock) disable iff (reset)
        w_valid_i |-> &w_i.strb)
        else begin
            fail_count++;
            $error("W strobes are not all set");
        end

    // last exactly on the eighth beat
    w_last: assert property (@(posedge clock) disable iff (reset)
        w_valid_i && w_ready_i |-> w_i.last == (w_beat == 3'(BEATS - 1)))
        else begin
            fail_count++;
            $error("W last not on the eighth beat");
        end

endmodule

bind sim_top line_sva u_sva (
    .clock      (clock),
    .reset      (reset),
    .aw_valid_i (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_i       (aw_o),
    .w_valid_i  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_i        (w_o),
    .ar_valid_i (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_i       (ar_o)
);

// File: tb_top.sv
`timescale 1ns/100ps

module tb_top;
    import line_pkg::*;

    localparam int CLK_NS      = 20;
    localparam int PAIR_CYCLES = 64;    // write plus read back without stalls
    // stalled pairs weigh double
    // the stop test adds its quiet window
    localparam int TEST_PAIRS  = 4 + 2 * 6 + 2 + 2 + 6;
    localparam int WATCHDOG_NS = 4 * TEST_PAIRS * PAIR_CYCLES * CLK_NS;

    logic        clock;
    logic        reset;
    logic        run;
    logic [3:0]  stall_rate;
    logic [19:0] rnd_bits;
    logic [31:0] rnd_state;
    logic        inject_slverr;
    logic        flip_bit;

    logic        aw_valid;
    logic        aw_ready;
    axi_ax_t     aw;
    logic        w_valid;
    logic        w_ready;
    axi_w_t      w;
    logic        b_valid;
    logic        b_ready;
    axi_b_t      b;
    logic        ar_valid;
    logic        ar_ready;
    axi_ax_t     ar;
    logic        r_valid;
    logic        r_ready;
    axi_r_t      r;
    logic [15:0] pair_count;
    logic [15:0] mismatch_count;
    logic [15:0] resp_err_count;

    int errors;
    int checks;
    int tests_run;

    sim_top dut0 (
        .clock(clock), .reset(reset), .run_i(run),
        .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_o(aw),
        .w_valid_o(w_valid), .w_ready_i(w_ready), .w_o(w),
        .b_valid_i(b_valid), .b_ready_o(b_ready), .b_i(b),
        .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_o(ar),
        .r_valid_i(r_valid), .r_ready_o(r_ready), .r_i(r),
        .pair_count_o(pair_count), .mismatch_count_o(mismatch_count),
        .resp_err_count_o(resp_err_count)
    );

    axi_mem_model mem0 (
        .clock(clock), .reset(reset), .stall_rate_i(stall_rate), .rnd_i(rnd_bits),
        .inject_slverr_i(inject_slverr), .flip_bit_i(flip_bit),
        .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_i(aw),
        .w_valid_i(w_valid), .w_ready_o(w_ready), .w_i(w),
        .b_valid_o(b_valid), .b_ready_i(b_ready), .b_o(b),
        .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_i(ar),
        .r_valid_o(r_valid), .r_ready_i(r_ready), .r_o(r)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_NS / 2) clock = ~clock;
    end

    // fibonacci with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // galois step where the bit shifted out lands on every tap position
    function automatic logic [DATA_W-1:0] pattern_next(input logic [DATA_W-1:0] s);
        logic [DATA_W-1:0] n;
        n = s >> 1;
        for (int i = 0; i < DATA_W; i++) begin
            if (PATTERN_TAPS[i]) begin
                n[i] = n[i] ^ s[0];
            end
        end
        return n;
    endfunction

    always @(posedge clock) begin
        #2;
        for (int i = 0; i < 20; i++) begin
            rnd_state   = lfsr_step(rnd_state);
            rnd_bits[i] = rnd_state[0];
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic drive_slot();
        @(posedge clock);
        #2;
    endtask

    task automatic wait_pairs(input logic [15:0] target);
        while (pair_count < target) begin
            @(negedge clock);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        repeat (IDLE_CYCLES - 2) begin
            @(negedge clock);
            check_value("aw_valid", 64'(aw_valid), 64'd0);
            check_value("w_valid", 64'(w_valid), 64'd0);
            check_value("ar_valid", 64'(ar_valid), 64'd0);
            check_value("b_ready", 64'(b_ready), 64'd0);
            check_value("r_ready", 64'(r_ready), 64'd0);
            check_value("pair_count", 64'(pair_count), 64'd0);
            check_value("mismatch_count", 64'(mismatch_count), 64'd0);
            check_value("resp_err_count", 64'(resp_err_count), 64'd0);
        end
        finish_test("reset state", e0);
    endtask

    task automatic test_clean_pairs();
        int e0;
        e0 = errors;
        wait_pairs(16'd4);
        check_value("mismatch_count", 64'(mismatch_count), 64'd0);
        check_value("resp_err_count", 64'(resp_err_count), 64'd0);
        check_value("write bursts", 64'(mem0.wr_addr_q.size()), 64'd4);
        for (int n = 0; n < 4 && n < mem0.wr_addr_q.size(); n++) begin
            check_value($sformatf("write address %0d", n), 64'(mem0.wr_addr_q[n]),
                        64'(BASE_ADDR + ADDR_W'(n * LINE_BYTES)));
        end
        finish_test("clean pairs", e0);
    endtask

    task automatic test_stalled_pairs();
        int                e0;
        int                k;
        logic [15:0]       p0;
        logic [15:0]       m0;
        logic [15:0]       r0;
        logic [DATA_W-1:0] pat;
        line_u             wline;
        e0  = errors;
        p0  = pair_count;
        m0  = mismatch_count;
        r0  = resp_err_count;
        k   = mem0.wr_addr_q.size();    // index of the next write
        pat = PATTERN_SEED;
        repeat (8 * k) pat = pattern_next(pat);
        drive_slot();
        stall_rate = 4'd6;
        wait_pairs(p0 + 16'd6);
        check_value("mismatch_count", 64'(mismatch_count), 64'(m0));
        check_value("resp_err_count", 64'(resp_err_count), 64'(r0));
        wline = mem0.wr_line_q[k];
        check_value("stalled write address", 64'(mem0.wr_addr_q[k]),
                    64'(BASE_ADDR + ADDR_W'(k * LINE_BYTES)));
        for (int i = 0; i < BEATS; i++) begin
            check_value($sformatf("write %0d beat %0d", k, i), wline.beat[i], pat);
            pat = pattern_next(pat);
        end
        finish_test("stalled pairs", e0);
    endtask

    task automatic test_flip_read();
        int          e0;
        logic [15:0] p0;
        logic [15:0] m0;
        e0 = errors;
        p0 = pair_count;
        m0 = mismatch_count;
        drive_slot();
        stall_rate = 4'd0;
        flip_bit   = 1'b1;      // next read comes back corrupted
        wait_pairs(p0 + 16'd1);
        drive_slot();
        flip_bit = 1'b0;
        check_value("mismatch_count", 64'(mismatch_count), 64'(m0 + 16'd1));
        wait_pairs(p0 + 16'd2);
        check_value("mismatch_count", 64'(mismatch_count), 64'(m0 + 16'd1));
        finish_test("flipped read", e0);
    endtask

    task automatic test_slverr_write();
        int          e0;
        logic [15:0] p0;
        logic [15:0] r0;
        e0 = errors;
        p0 = pair_count;
        r0 = resp_err_count;
        drive_slot();
        inject_slverr = 1'b1;
        wait_pairs(p0 + 16'd1);
        drive_slot();
        inject_slverr = 1'b0;
        check_value("resp_err_count", 64'(resp_err_count), 64'(r0 + 16'd1));
        wait_pairs(p0 + 16'd2);     // loop keeps going after the error
        check_value("resp_err_count", 64'(resp_err_count), 64'(r0 + 16'd1));
        finish_test("slverr write", e0);
    endtask

    task automatic test_run_stop();
        int          e0;
        logic [15:0] p0;
        logic        aw_seen;
        e0      = errors;
        aw_seen = 1'b0;
        while (!(aw_valid && aw_ready)) begin
            @(negedge clock);
        end
        p0 = pair_count;
        drive_slot();
        run = 1'b0;     // the pair in flight still completes
        wait_pairs(p0 + 16'd1);
        repeat (4 * PAIR_CYCLES) begin
            @(negedge clock);
            aw_seen = aw_seen | aw_valid;
        end
        check_value("aw_valid after stop", 64'(aw_seen), 64'd0);
        check_value("pair_count", 64'(pair_count), 64'(p0 + 16'd1));
        finish_test("run stop", e0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        run           = 1'b1;
        stall_rate    = 4'd0;
        rnd_bits      = '0;
        rnd_state     = 32'h32d69eea;
        inject_slverr = 1'b0;
        flip_bit      = 1'b0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;

        test_reset_state();
        test_clean_pairs();
        test_stalled_pairs();
        test_flip_read();
        test_slverr_write();
        test_run_stop();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, checks, errors, dut0.u_sva.fail_count);
        if (errors == 0 && dut0.u_sva.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: list.f
line_pkg.sv
line_req_gen.sv
axi_burst_master.sv
line_check.sv
sim_top.sv
axi_mem_model.sv
line_sva.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# builds the line transfer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top \
    --Mdir obj_dir -o tb_top_sim -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: Verilator build failed with status $status"
    exit 1
fi

# keep going after an assertion error so the testbench can print its summary
./obj_dir/tb_top_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
echo "run.sh: pass line not found in sim.log"
exit 1
